// File: source/vdu_pkg.sv
// shared constants, types and host write struct for the character display, imported by every module
package vdu_pkg;

	localparam int H_RES      = 288;  // active pixels per line
	localparam int V_RES      = 528;  // active lines per frame
	localparam int H_BLANK    = 64;   // blanking clocks before each line
	localparam int V_BLANK    = 8;    // blanking lines before each frame
	localparam int H_SYNC_LEN = 16;
	localparam int V_SYNC_LEN = 2;
	localparam int X_OFFSET   = 16;   // left margin of the character area
	localparam int Y_OFFSET   = 8;    // top margin of the character area
	localparam int SCALE      = 1;    // pixel stretch is 2^SCALE
	localparam int H_CHARS    = 16;
	localparam int V_CHARS    = 32;
	localparam int FONT_W     = 8;
	localparam int FONT_H     = 8;
	localparam int FONT_CHARS = 64;
	localparam int CORDW      = 16;   // signed coordinate width

	localparam int STRETCH    = 1 << SCALE;          // clocks per glyph bit
	localparam int SCAN_W     = FONT_W * H_CHARS;    // scanline buffer width
	localparam int TEXT_LINES = FONT_H * V_CHARS;    // unscaled lines of text
	localparam int VRAM_DEPTH = H_CHARS * V_CHARS;
	localparam int FONT_DEPTH = FONT_CHARS * FONT_H;

	typedef logic signed [CORDW-1:0]           coord_t;
	typedef logic [$clog2(VRAM_DEPTH)-1:0]     vaddr_t;
	typedef logic [$clog2(FONT_DEPTH)-1:0]     faddr_t;  // code * 8 + glyph row
	typedef logic [7:0]                        byte_t;

	typedef enum logic [2:0] {IDLE, FETCH, FILL, WAIT_POS, LINE} char_state_t;

	typedef struct packed {
		logic   we;
		vaddr_t addr;
		byte_t  data;
	} host_wr_t;

endpackage

// File: source/display_timing.sv
// raster timing generator giving signed screen coordinates, syncs, display enable and strobes
`timescale 1ns/1ps

module display_timing import vdu_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	output coord_t o_sx,
	output coord_t o_sy,
	output logic   o_hsync,
	output logic   o_vsync,
	output logic   o_de,
	output logic   o_line,
	output logic   o_frame
);

	coord_t nx;  // next horizontal position
	coord_t ny;  // next vertical position

	always_comb begin
		if (o_sx == coord_t'(H_RES - 1)) begin
			nx = coord_t'(-H_BLANK);  // wrap to start of line
			ny = (o_sy == coord_t'(V_RES - 1)) ? coord_t'(-V_BLANK) : o_sy + 1'b1;
		end else begin
			nx = o_sx + 1'b1;
			ny = o_sy;
		end
	end

	// decodes use the next position so they line up with the registered counters
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_sx    <= coord_t'(-H_BLANK);
			o_sy    <= coord_t'(-V_BLANK);
			o_hsync <= 1'b0;
			o_vsync <= 1'b0;
			o_de    <= 1'b0;
			o_line  <= 1'b0;
			o_frame <= 1'b0;
		end else begin
			o_sx    <= nx;
			o_sy    <= ny;
			o_hsync <= (nx < coord_t'(H_SYNC_LEN - H_BLANK));
			o_vsync <= (ny < coord_t'(V_SYNC_LEN - V_BLANK));  // whole lines
			o_de    <= (nx >= 0) && (ny >= 0);
			o_line  <= (nx == coord_t'(-H_BLANK));
			o_frame <= (nx == coord_t'(-H_BLANK)) && (ny == coord_t'(-V_BLANK));
		end
	end

endmodule

// File: source/display_ram.sv
// text screen memory, written by the host and read one clock late by the character engine
`timescale 1ns/1ps

module display_ram import vdu_pkg::*; (
	input  logic     i_clk,
	input  host_wr_t i_wr,
	input  logic     i_rd_en,
	input  vaddr_t   i_rd_addr,
	output byte_t    o_rd_data
);

	byte_t mem [VRAM_DEPTH];  // 16 columns by 32 rows

	always_ff @(posedge i_clk) begin
		if (i_wr.we) begin
			mem[i_wr.addr] <= i_wr.data;
		end
		if (i_rd_en) begin
			o_rd_data <= mem[i_rd_addr];  // holds while idle
		end
	end

endmodule

// File: source/font_ram.sv
// loadable glyph memory for 64 characters of 8x8, host written and read combinationally
`timescale 1ns/1ps

module font_ram import vdu_pkg::*; (
	input  logic     i_clk,
	input  host_wr_t i_wr,
	input  faddr_t   i_addr,
	output byte_t    o_data
);

	byte_t mem [FONT_DEPTH];  // one byte per glyph row, bit 7 leftmost

	always_ff @(posedge i_clk) begin
		if (i_wr.we) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	assign o_data = mem[i_addr];  // async lookup during fill

endmodule

// File: source/char_gen.sv
// character generator engine: fetches a text row into a scanline buffer and shifts it out
`timescale 1ns/1ps

module char_gen import vdu_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  logic   i_en,
	input  logic   i_line,
	input  coord_t i_sx,
	input  coord_t i_sy,
	output logic   o_rd_en,
	output vaddr_t o_rd_addr,
	input  byte_t  i_rd_data,
	output faddr_t o_font_addr,
	input  byte_t  i_font_data,
	output logic   o_pixel
);

	coord_t                    line_idx;    // scaled line inside the text area
	logic                      row_active;  // current line shows text
	logic                      line_end;
	logic [SCAN_W-1:0]         scanline;    // glyph rows of the whole text row
	logic [$clog2(SCAN_W)-1:0] bit_cnt;     // char index in fill, bit index in line
	logic [SCALE:0]            cnt_x;       // pixel stretch counter
	char_state_t               state;

	always_comb begin
		line_idx   = (i_sy - coord_t'(Y_OFFSET)) >>> SCALE;
		row_active = (line_idx >= 0) && (line_idx < coord_t'(TEXT_LINES));
		line_end   = (i_sx == coord_t'(H_RES - X_OFFSET));
	end

	// only the low 6 bits select a glyph
	assign o_font_addr = {i_rd_data[5:0], line_idx[2:0]};
	assign o_rd_en     = (state == FETCH) || (state == FILL);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= IDLE;
			o_pixel <= 1'b0;
			bit_cnt <= '0;
			cnt_x   <= '0;
		end else begin
			case (state)
				IDLE: begin
					o_pixel <= 1'b0;
					if (i_en && i_line && row_active) begin
						bit_cnt   <= $clog2(SCAN_W)'(H_CHARS - 1);  // leftmost char first
						o_rd_addr <= {line_idx[7:3], 4'b0000};     // row * 16
						state     <= FETCH;
					end
				end

				FETCH: begin
					state <= FILL;  // display byte arrives this edge
				end

				FILL: begin
					scanline[FONT_W * bit_cnt + FONT_W - 1 -: FONT_W] <= i_font_data;
					o_rd_addr <= o_rd_addr + 1'b1;
					bit_cnt   <= bit_cnt - 1'b1;
					state     <= (bit_cnt == 0) ? WAIT_POS : FETCH;
				end

				WAIT_POS: begin
					if (i_sx == coord_t'(X_OFFSET)) begin
						cnt_x   <= '0;
						bit_cnt <= $clog2(SCAN_W)'(SCAN_W - 1);
						state   <= LINE;
					end
				end

				LINE: begin
					o_pixel <= scanline[bit_cnt];
					if (cnt_x == (SCALE + 1)'(STRETCH - 1)) begin
						cnt_x   <= '0;
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == 0) begin
							state <= IDLE;  // last bit out
						end
					end else begin
						cnt_x <= cnt_x + 1'b1;
					end
					if (line_end) begin
						state <= IDLE;  // never run past the right margin
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: source/vdu_top.sv
// display top level joining raster timing, screen and font memories and the character engine
`timescale 1ns/1ps

module vdu_top import vdu_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_en,
	input  host_wr_t i_ram_wr,
	input  host_wr_t i_font_wr,
	output coord_t   o_sx,
	output coord_t   o_sy,
	output logic     o_hsync,
	output logic     o_vsync,
	output logic     o_de,
	output logic     o_pixel
);

	logic   line;       // line start strobe
	logic   rd_en;
	vaddr_t rd_addr;
	byte_t  rd_data;    // character code, one clock after the read
	faddr_t font_addr;
	byte_t  font_data;

	display_timing u_display_timing (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.o_sx    (o_sx),
		.o_sy    (o_sy),
		.o_hsync (o_hsync),
		.o_vsync (o_vsync),
		.o_de    (o_de),
		.o_line  (line),
		.o_frame ()  // frame start not needed by the engine
	);

	display_ram u_display_ram (
		.i_clk     (i_clk),
		.i_wr      (i_ram_wr),
		.i_rd_en   (rd_en),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	font_ram u_font_ram (
		.i_clk  (i_clk),
		.i_wr   (i_font_wr),
		.i_addr (font_addr),
		.o_data (font_data)
	);

	char_gen u_char_gen (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_en        (i_en),
		.i_line      (line),
		.i_sx        (o_sx),
		.i_sy        (o_sy),
		.o_rd_en     (rd_en),
		.o_rd_addr   (rd_addr),
		.i_rd_data   (rd_data),
		.o_font_addr (font_addr),
		.i_font_data (font_data),
		.o_pixel     (o_pixel)
	);

endmodule

// File: test/tb_clock.sv
// free-running testbench clock source, instanced once by the testbench top
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#50 o_clk = ~o_clk;  // 100 ns period
		end
	end

endmodule

// File: test/vdu_props.sv
// assertions on the character engine state machine, bound into char_gen by the testbench
`timescale 1ns/1ps

module vdu_props import vdu_pkg::*; (
	input logic        i_clk,
	input logic        i_rst,
	input char_state_t i_state,
	input logic        i_rd_en,
	input logic        i_pixel
);

	// display memory is read only while walking the text row
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_rd_en |-> (i_state == FETCH || i_state == FILL))
	else $error("display memory read outside fetch and fill");

	// first idle clock still shows the last bit of the line
	assert property (@(posedge i_clk) disable iff (i_rst)
		(i_state == IDLE && $past(i_state) == IDLE) |-> !i_pixel)
	else $error("pixel active while the engine is idle");

	assert property (@(posedge i_clk) disable iff (i_rst)
		i_state inside {IDLE, FETCH, FILL, WAIT_POS, LINE})
	else $error("engine state outside the defined set");

endmodule

// File: test/tb_vdu.sv
// testbench for the character display, replays the stimulus file and checks pixels and syncs
`timescale 1ns/1ps

module tb_vdu import vdu_pkg::*; ();

	logic     clk;
	logic     rst;
	logic     en;
	host_wr_t ram_wr;
	host_wr_t font_wr;
	coord_t   sx;
	coord_t   sy;
	logic     hsync;
	logic     vsync;
	logic     de;
	logic     pixel;
	int       errors;
	int       frames;
	int       samples;
	bit       timed_out;
	int       hx1;
	int       hy1;
	int       hx2;            // position two clocks back, matches o_pixel
	int       hy2;
	logic     pix_map [int];  // captured pixel, key y * 1024 + x
	int       cq_y [$];
	int       cq_x [$];
	int       cq_v [$];

	tb_clock u_tb_clock (.o_clk(clk));

	vdu_top u_vdu_top (
		.i_clk(clk), .i_rst(rst), .i_en(en), .i_ram_wr(ram_wr), .i_font_wr(font_wr),
		.o_sx(sx), .o_sy(sy), .o_hsync(hsync), .o_vsync(vsync), .o_de(de), .o_pixel(pixel)
	);

	bind char_gen vdu_props u_vdu_props (
		.i_clk(i_clk), .i_rst(i_rst), .i_state(state), .i_rd_en(o_rd_en), .i_pixel(o_pixel)
	);

	task automatic report_value(string name, logic signed [31:0] expected,
		logic signed [31:0] actual);
		errors++;
		$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
	endtask

	task automatic report_problem(string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	// one clock, shifting the position history first
	task automatic step();
		hx2 = hx1;
		hy2 = hy1;
		hx1 = int'(sx);
		hy1 = int'(sy);
		@(negedge clk);
	endtask

	task automatic write_ram(int addr, int data);
		ram_wr = '{we: 1'b1, addr: vaddr_t'(addr), data: byte_t'(data)};
		step();
		ram_wr.we = 1'b0;
	endtask

	task automatic write_font(int addr, int data);
		font_wr = '{we: 1'b1, addr: vaddr_t'(addr), data: byte_t'(data)};
		step();
		font_wr.we = 1'b0;
	endtask

	// both memories are 512 deep, blank code 0 and empty glyphs
	task automatic clear_memories();
		for (int i = 0; i < VRAM_DEPTH; i++) begin
			ram_wr  = '{we: 1'b1, addr: vaddr_t'(i), data: 8'h00};
			font_wr = '{we: 1'b1, addr: vaddr_t'(i), data: 8'h00};
			step();
			if ({pixel, de} !== 2'b00) begin
				report_value("pixel and enable before first frame", 0, 32'({pixel, de}));
			end
		end
		ram_wr.we  = 1'b0;
		font_wr.we = 1'b0;
	endtask

	task automatic wait_frame_start();
		int n;
		n = 0;
		while (!(int'(sx) == -H_BLANK && int'(sy) == -V_BLANK)) begin
			if (n >= (H_BLANK + H_RES) * (V_BLANK + V_RES)) begin
				report_problem("timed out waiting for the start of a frame");
				timed_out = 1'b1;
				break;
			end
			step();
			n++;
		end
	endtask

	task automatic run_frame();
		int   hs_pulses;
		int   vs_pulses;
		int   de_clks;
		int   ex;
		int   ey;
		int   y;
		int   x;
		int   v;
		logic prev_hs;
		logic prev_vs;
		bit   in_area;
		bit   de_exp;
		bit   hs_exp;
		bit   vs_exp;
		hs_pulses = 0;
		vs_pulses = 0;
		de_clks   = 0;
		prev_hs   = 1'b0;
		prev_vs   = 1'b0;
		ex        = -H_BLANK;
		ey        = -V_BLANK;
		wait_frame_start();
		if (timed_out) return;
		for (int n = 0; n < (H_BLANK + H_RES) * (V_BLANK + V_RES); n++) begin
			in_area = hx2 >= X_OFFSET && hx2 < X_OFFSET + SCAN_W * STRETCH
				&& hy2 >= Y_OFFSET && hy2 < Y_OFFSET + TEXT_LINES * STRETCH;
			if (hx2 >= 0 && hy2 >= 0) pix_map[hy2 * 1024 + hx2] = pixel;
			if (pixel !== 1'b0 && (!in_area || !en)) begin
				report_value($sformatf("blank pixel y=%0d x=%0d", hy2, hx2), 0, 32'(pixel));
			end
			if (sx !== coord_t'(ex)) begin
				report_value($sformatf("horizontal position on line %0d", ey), ex, sx);
			end
			if (sy !== coord_t'(ey)) begin
				report_value($sformatf("vertical position at column %0d", ex), ey, sy);
			end
			de_exp = ex >= 0 && ey >= 0;
			hs_exp = ex < H_SYNC_LEN - H_BLANK;  // first clocks of each line
			vs_exp = ey < V_SYNC_LEN - V_BLANK;
			if (de !== de_exp) begin
				report_value($sformatf("display enable y=%0d x=%0d", ey, ex), 32'(de_exp), 32'(de));
			end
			if (hsync !== hs_exp) begin
				report_value($sformatf("hsync y=%0d x=%0d", ey, ex), 32'(hs_exp), 32'(hsync));
			end
			if (vsync !== vs_exp) begin
				report_value($sformatf("vsync y=%0d x=%0d", ey, ex), 32'(vs_exp), 32'(vsync));
			end
			hs_pulses += int'(hsync && !prev_hs);
			vs_pulses += int'(vsync && !prev_vs);
			de_clks   += int'(de);
			prev_hs = hsync;
			prev_vs = vsync;
			step();
			if (ex == H_RES - 1) begin
				ex = -H_BLANK;
				ey = (ey == V_RES - 1) ? -V_BLANK : ey + 1;
			end else begin
				ex++;
			end
		end
		if (hs_pulses != V_BLANK + V_RES) report_value("hsync pulses", V_BLANK + V_RES, hs_pulses);
		if (vs_pulses != 1) report_value("vsync pulses", 1, vs_pulses);
		if (de_clks != H_RES * V_RES) report_value("display enable clocks", H_RES * V_RES, de_clks);
		while (cq_y.size() > 0) begin
			y = cq_y.pop_front();
			x = cq_x.pop_front();
			v = cq_v.pop_front();
			samples++;
			if (pix_map[y * 1024 + x] !== 1'(v)) begin
				report_value($sformatf("pixel y=%0d x=%0d", y, x), v, 32'(pix_map[y * 1024 + x]));
			end
		end
		frames++;
	endtask

	initial begin
		int    fd;
		int    a;
		int    b;
		int    d;
		int    n;
		string line;
		rst = 1'b1;
		en = 1'b0;
		ram_wr = '0;
		font_wr = '0;
		for (int i = 0; i < 5; i++) begin
			step();
			if ({pixel, hsync, vsync, de} !== 4'b0000) begin
				report_value("outputs in reset", 0, 32'({pixel, hsync, vsync, de}));
			end
		end
		rst = 1'b0;
		clear_memories();
		fd = $fopen("vdu_stimulus.txt", "r");
		if (fd == 0) report_problem("cannot open vdu_stimulus.txt");
		while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
			case (line.getc(0))
				"R": begin
					n = $sscanf(line, "R %h %h", a, b);
					if (n != 2) report_problem("malformed display memory record in stimulus");
					write_ram(a, b);
				end
				"G": begin
					n = $sscanf(line, "G %h %h %h", a, b, d);
					if (n != 3) report_problem("malformed glyph record in stimulus");
					write_font(a * FONT_H + b, d);  // code * 8 + glyph row
				end
				"E": begin
					n = $sscanf(line, "E %d", a);
					if (n != 1) report_problem("malformed enable record in stimulus");
					en = (a != 0);
				end
				"C": begin
					n = $sscanf(line, "C %d %d %d", a, b, d);
					if (n != 3) report_problem("malformed pixel sample record in stimulus");
					cq_y.push_back(a);
					cq_x.push_back(b);
					cq_v.push_back(d);
				end
				"F": run_frame();
				default: ;  // comments and blank lines
			endcase
		end
		if (fd != 0) $fclose(fd);
		$display("frames %0d, pixel samples %0d, errors %0d", frames, samples, errors);
		if (errors == 0 && frames > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vdu_stimulus.txt
# R addr data (hex) screen cell write, G code row data (hex) glyph row write
# E level, C y x pixel (decimal) expected sample, F run one frame and check
G 01 0 81
G 01 1 42
G 01 7 81
G 02 0 F0
G 02 7 0F
R 000 01
R 1FF 02
R 108 41
E 1
C 7 16 0
C 8 15 0
C 8 16 1
C 9 17 1
C 8 18 0
C 8 31 1
C 10 18 1
C 23 30 1
C 504 256 1
C 504 264 0
C 519 271 1
C 519 272 0
C 520 271 0
C 264 144 1
C 265 159 1
C 264 146 0
F
R 000 02
C 8 16 1
C 8 24 0
C 8 31 0
C 23 30 1
C 23 16 0
F
E 0
F

// File: tb.f
source/vdu_pkg.sv
source/display_timing.sv
source/display_ram.sv
source/font_ram.sv
source/char_gen.sv
source/vdu_top.sv
test/tb_clock.sv
test/vdu_props.sv
test/tb_vdu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       ?= tb_vdu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
